/* source/exec_pkg.sv */
//----------------------------------------------------------
// execute stage shared types
// widths, micro-op codes and the request/result structs
//----------------------------------------------------------

package exec_pkg;

  //----------------------------------------------------------
  // widths
  //----------------------------------------------------------

  localparam int data_bits     = 32; // rv32 operands
  localparam int reg_addr_bits = 5;  // x0..x31
  localparam int uop_bits      = 4;

  // top two uop bits for the multiply class
  localparam logic [1:0] mul_class = 2'b11;

  //----------------------------------------------------------
  // micro-op codes
  //----------------------------------------------------------

  // 4'b1010 and 4'b1011 left unused
  typedef enum logic [uop_bits-1:0] {
    op_add    = 4'b0000,
    op_sub    = 4'b0001,
    op_and    = 4'b0010,
    op_or     = 4'b0011,
    op_xor    = 4'b0100,
    op_sll    = 4'b0101,
    op_srl    = 4'b0110,
    op_sra    = 4'b0111,
    op_slt    = 4'b1000,
    op_sltu   = 4'b1001,
    op_mul    = 4'b1100, // multiply class starts here
    op_mulh   = 4'b1101,
    op_mulhsu = 4'b1110,
    op_mulhu  = 4'b1111
  } exec_uop;

  // op class from the code alone
  function automatic logic is_mul_op(exec_uop uop);
    return uop[uop_bits-1 -: 2] == mul_class;
  endfunction

  //----------------------------------------------------------
  // link payloads
  //----------------------------------------------------------

  typedef struct packed {
    exec_uop                  uop;
    logic [data_bits-1:0]     op1;
    logic [data_bits-1:0]     op2;
    logic [reg_addr_bits-1:0] waddr; // destination reg
  } exec_req; // 73 bits

  typedef struct packed {
    logic                     wen;   // low for x0
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
  } exec_resp; // 38 bits

endpackage

/* source/exec_issue.sv */
//----------------------------------------------------------
// execute issue register
// holds one decoded micro-op and steers it to the alu or
// the multiplier by op class
//----------------------------------------------------------

`timescale 1ns/1ns

module exec_issue import exec_pkg::*; (
  input  logic    clk,
  input  logic    rst,

  // from decode
  input  logic    req_val,
  output logic    req_rdy,
  input  exec_req req,

  // to alu
  output logic    alu_val,
  input  logic    alu_rdy,
  output exec_req alu_req,

  // to multiplier
  output logic    mul_val,
  input  logic    mul_rdy,
  output exec_req mul_req
);

  logic    issue_val;    // register occupied
  exec_req issue_q;      // held micro-op
  logic    issue_is_mul; // class of held op
  logic    target_rdy;   // ready of the chosen unit
  logic    in_xfer;
  logic    out_xfer;

  //----------------------------------------------------------
  // steering
  //----------------------------------------------------------

  assign issue_is_mul = is_mul_op(issue_q.uop); // decoded once here
  assign target_rdy   = issue_is_mul ? mul_rdy : alu_rdy;

  assign alu_val = issue_val & ~issue_is_mul;
  assign mul_val = issue_val & issue_is_mul;
  assign alu_req = issue_q;
  assign mul_req = issue_q;

  // empty, or draining into its unit this cycle
  assign req_rdy  = ~issue_val | target_rdy;
  assign in_xfer  = req_val & req_rdy;
  assign out_xfer = issue_val & target_rdy;

  //----------------------------------------------------------
  // issue register
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_val <= 1'b0;
    end else if (in_xfer) begin
      issue_val <= 1'b1; // refill, may overlap a drain
    end else if (out_xfer) begin
      issue_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      issue_q <= req;
    end
  end

endmodule

/* source/exec_alu.sv */
//----------------------------------------------------------
// integer alu execute unit
// one-entry input register, result formed combinationally
//----------------------------------------------------------

`timescale 1ns/1ns

module exec_alu import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  // from issue
  input  logic     req_val,
  output logic     req_rdy,
  input  exec_req  req,

  // to writeback arbiter
  output logic     resp_val,
  input  logic     resp_rdy,
  output exec_resp resp
);

  logic                 val_q; // input register full
  exec_req              req_q; // registered operands
  logic                 req_xfer;
  logic                 resp_xfer;
  logic [4:0]           shamt;
  logic [data_bits-1:0] result;

  //----------------------------------------------------------
  // input register
  //----------------------------------------------------------

  assign req_rdy   = resp_rdy | ~val_q;
  assign req_xfer  = req_val & req_rdy;
  assign resp_xfer = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (req_xfer) begin
      val_q <= 1'b1;
    end else if (resp_xfer) begin
      val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      req_q <= req; // latched on acceptance
    end
  end

  //----------------------------------------------------------
  // operations
  //----------------------------------------------------------

  assign shamt = req_q.op2[4:0]; // rv32 shifts use 5 bits

  always_comb begin
    case (req_q.uop)
      op_add:  result = req_q.op1 + req_q.op2;
      op_sub:  result = req_q.op1 - req_q.op2;
      op_and:  result = req_q.op1 & req_q.op2;
      op_or:   result = req_q.op1 | req_q.op2;
      op_xor:  result = req_q.op1 ^ req_q.op2;
      op_sll:  result = req_q.op1 << shamt;
      op_srl:  result = req_q.op1 >> shamt;
      op_sra:  result = $signed(req_q.op1) >>> shamt; // sign fill
      op_slt:  result = {{(data_bits-1){1'b0}}, $signed(req_q.op1) < $signed(req_q.op2)};
      op_sltu: result = {{(data_bits-1){1'b0}}, req_q.op1 < req_q.op2};
      default: result = '0; // multiply and spare codes never steered here
    endcase
  end

  // result port
  assign resp_val   = val_q;
  assign resp.wen   = req_q.waddr != '0; // x0 stays zero
  assign resp.waddr = req_q.waddr;
  assign resp.wdata = result;

endmodule

/* source/exec_multiplier.sv */
//----------------------------------------------------------
// multiply execute unit
// rv32m mul, mulh, mulhsu and mulhu from one 64-bit product
//----------------------------------------------------------

`timescale 1ns/1ns

module exec_multiplier import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  // from issue
  input  logic     req_val,
  output logic     req_rdy,
  input  exec_req  req,

  // to writeback arbiter
  output logic     resp_val,
  input  logic     resp_rdy,
  output exec_resp resp
);

  logic                   val_q;
  exec_req                req_q;
  logic                   req_xfer;
  logic                   resp_xfer;
  logic                   op1_signed; // sign extend op1
  logic                   op2_signed; // sign extend op2
  logic [2*data_bits-1:0] mul_a;
  logic [2*data_bits-1:0] mul_b;
  logic [2*data_bits-1:0] product;

  //----------------------------------------------------------
  // input register
  //----------------------------------------------------------

  assign req_rdy   = resp_rdy | ~val_q; // pass ready through when draining
  assign req_xfer  = req_val & req_rdy;
  assign resp_xfer = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (req_xfer) begin
      val_q <= 1'b1;
    end else if (resp_xfer) begin
      val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      req_q <= req;
    end
  end

  //----------------------------------------------------------
  // product
  //----------------------------------------------------------

  // mulh is signed*signed, mulhsu signed*unsigned
  assign op1_signed = (req_q.uop == op_mulh) | (req_q.uop == op_mulhsu);
  assign op2_signed = (req_q.uop == op_mulh);

  // extend to 64 bits, low 64 of the product then exact
  assign mul_a   = {{data_bits{op1_signed & req_q.op1[data_bits-1]}}, req_q.op1};
  assign mul_b   = {{data_bits{op2_signed & req_q.op2[data_bits-1]}}, req_q.op2};
  assign product = mul_a * mul_b;

  assign resp_val   = val_q;
  assign resp.wen   = req_q.waddr != '0; // suppress x0 writes
  assign resp.waddr = req_q.waddr;
  assign resp.wdata = (req_q.uop == op_mul) ? product[data_bits-1:0]
                                            : product[2*data_bits-1:data_bits]; // high word

endmodule

/* source/exec_wb_arbiter.sv */
//----------------------------------------------------------
// writeback arbiter
// round-robin merge of alu and multiplier results into one
// registered writeback port
//----------------------------------------------------------

`timescale 1ns/1ns

module exec_wb_arbiter import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  // alu results
  input  logic     alu_resp_val,
  output logic     alu_resp_rdy,
  input  exec_resp alu_resp,

  // multiplier results
  input  logic     mul_resp_val,
  output logic     mul_resp_rdy,
  input  exec_resp mul_resp,

  // writeback port
  output logic     wb_val,
  input  logic     wb_rdy,
  output exec_resp wb
);

  logic     wb_val_q;
  exec_resp wb_q;
  logic     last_mul;  // last grant went to the multiplier
  logic     grant_alu;
  logic     grant_mul;
  logic     out_free;  // output reg can take a result
  logic     take;

  //----------------------------------------------------------
  // grant
  //----------------------------------------------------------

  // on a tie the side not granted last time wins
  assign grant_mul = mul_resp_val & (~alu_resp_val | ~last_mul);
  assign grant_alu = alu_resp_val & ~grant_mul;

  assign out_free     = ~wb_val_q | wb_rdy;
  assign alu_resp_rdy = out_free & grant_alu;
  assign mul_resp_rdy = out_free & grant_mul;
  assign take         = out_free & (grant_alu | grant_mul);

  //----------------------------------------------------------
  // output register
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_val_q <= 1'b0;
      last_mul <= 1'b0;
    end else begin
      if (out_free) begin
        wb_val_q <= grant_alu | grant_mul; // refill or empty out
      end
      if (take) begin
        last_mul <= grant_mul;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      wb_q <= grant_mul ? mul_resp : alu_resp;
    end
  end

  assign wb_val = wb_val_q;
  assign wb     = wb_q;

endmodule

/* source/exec_stage.sv */
//----------------------------------------------------------
// execute stage top
// issue register, alu, multiplier and writeback arbiter
//----------------------------------------------------------

`timescale 1ns/1ns

module exec_stage import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  // decode side
  input  logic     req_val,
  output logic     req_rdy,
  input  exec_req  req,

  // writeback side
  output logic     wb_val,
  input  logic     wb_rdy,
  output exec_resp wb
);

  // issue to units
  logic     alu_val;
  logic     alu_rdy;
  exec_req  alu_req;
  logic     mul_val;
  logic     mul_rdy;
  exec_req  mul_req;

  // units to arbiter
  logic     alu_resp_val;
  logic     alu_resp_rdy;
  exec_resp alu_resp;
  logic     mul_resp_val;
  logic     mul_resp_rdy;
  exec_resp mul_resp;

  //----------------------------------------------------------
  // instances
  //----------------------------------------------------------

  exec_issue i_issue (
    .clk     (clk),
    .rst     (rst),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req     (req),
    .alu_val (alu_val),
    .alu_rdy (alu_rdy),
    .alu_req (alu_req),
    .mul_val (mul_val),
    .mul_rdy (mul_rdy),
    .mul_req (mul_req)
  );

  exec_alu i_alu (
    .clk      (clk),
    .rst      (rst),
    .req_val  (alu_val),
    .req_rdy  (alu_rdy),
    .req      (alu_req),
    .resp_val (alu_resp_val),
    .resp_rdy (alu_resp_rdy),
    .resp     (alu_resp)
  );

  exec_multiplier i_mul (
    .clk      (clk),
    .rst      (rst),
    .req_val  (mul_val),
    .req_rdy  (mul_rdy),
    .req      (mul_req),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp     (mul_resp)
  );

  exec_wb_arbiter i_wb_arb (
    .clk          (clk),
    .rst          (rst),
    .alu_resp_val (alu_resp_val),
    .alu_resp_rdy (alu_resp_rdy),
    .alu_resp     (alu_resp),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_resp     (mul_resp),
    .wb_val       (wb_val),
    .wb_rdy       (wb_rdy),
    .wb           (wb)
  );

endmodule

/* testbench/exec_stage_tb.sv */
//----------------------------------------------------------
// execute stage testbench
// lcg stimulus, reference model and per-unit expected
// queues matched on the writeback port
//----------------------------------------------------------

`timescale 1ns/1ns

module exec_stage_tb import exec_pkg::*; ();

  localparam logic [31:0] seed = 32'h7e61_6155;
  localparam int n_edge    = 6;   // edge operands per side
  localparam int n_rand    = 16;  // random pairs per op
  localparam int n_zero    = 64;  // waddr counter passes x0 twice
  localparam int n_mixed   = 200;
  localparam int n_stall   = 300;
  localparam int total_ops = 14 * (n_edge * n_edge + n_rand) + n_zero + n_mixed + n_stall;

  typedef struct packed {
    exec_resp    resp;
    logic [31:0] accept_cycle; // cycle of the req transfer
  } expect_entry;

  logic        clk;
  logic        rst;
  logic        req_val;
  logic        req_rdy;
  exec_req     req;
  logic        wb_val;
  logic        wb_rdy;
  exec_resp    wb;
  logic        stall_en;         // random wb_rdy when set
  logic [31:0] op_state;         // lcg for operands and ops
  logic [31:0] stall_state;      // lcg for wb_rdy
  logic [4:0]  next_waddr;       // wraps every 32 issues
  expect_entry alu_q[$];
  expect_entry mul_q[$];
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          zero_seen = 0;    // x0 results seen with wen low
  int          issued = 0;
  int unsigned cycle_cnt = 0;

  exec_stage i_dut (
    .clk     (clk),
    .rst     (rst),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req     (req),
    .wb_val  (wb_val),
    .wb_rdy  (wb_rdy),
    .wb      (wb)
  );

  //----------------------------------------------------------
  // stimulus helpers and reference model
  //----------------------------------------------------------

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    op_state = lcg_next(op_state);
    return op_state;
  endfunction

  // 0..9 alu codes, 10..13 the multiply codes
  function automatic exec_uop uop_at(int i);
    return (i < 10) ? exec_uop'(i) : exec_uop'(i + 2);
  endfunction

  function automatic logic [31:0] edge_val(int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h0000_001f; // shift 31
      3:       return 32'h7fff_ffff;
      4:       return 32'h8000_0000; // most negative
      default: return 32'hffff_ffff; // -1
    endcase
  endfunction

  function automatic logic is_multiply(exec_uop u);
    return u[3:2] == 2'b11;
  endfunction

  function automatic exec_resp exec_model(exec_req r);
    exec_resp           res;
    logic signed [63:0] a_s;
    logic signed [63:0] b_s;
    logic signed [63:0] prod;
    res.waddr = r.waddr;
    res.wen   = (r.waddr != 5'd0);
    a_s = r.op1; // zero extended, overridden for signed ops
    b_s = r.op2;
    if (r.uop == op_mulh || r.uop == op_mulhsu) a_s = $signed(r.op1);
    if (r.uop == op_mulh) b_s = $signed(r.op2);
    prod = a_s * b_s; // exact mod 2^64
    case (r.uop)
      op_add:  res.wdata = r.op1 + r.op2;
      op_sub:  res.wdata = r.op1 - r.op2;
      op_and:  res.wdata = r.op1 & r.op2;
      op_or:   res.wdata = r.op1 | r.op2;
      op_xor:  res.wdata = r.op1 ^ r.op2;
      op_sll:  res.wdata = r.op1 << r.op2[4:0];
      op_srl:  res.wdata = r.op1 >> r.op2[4:0];
      op_sra:  res.wdata = $signed(r.op1) >>> r.op2[4:0];
      op_slt:  res.wdata = ($signed(r.op1) < $signed(r.op2)) ? 32'd1 : 32'd0;
      op_sltu: res.wdata = (r.op1 < r.op2) ? 32'd1 : 32'd0;
      op_mul:  res.wdata = prod[31:0];
      default: res.wdata = prod[63:32]; // mulh, mulhsu, mulhu
    endcase
    return res;
  endfunction

  //----------------------------------------------------------
  // compare tasks
  //----------------------------------------------------------

  task automatic check_resp(input exec_resp got, input exec_resp exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      if (got.wen !== exp.wen) $display("[FAIL] wb.wen: got %h expected %h", got.wen, exp.wen);
      if (got.waddr !== exp.waddr)
        $display("[FAIL] wb.waddr: got %h expected %h", got.waddr, exp.waddr);
      if (got.wdata !== exp.wdata)
        $display("[FAIL] wb.wdata: got %h expected %h (x%0d)", got.wdata, exp.wdata, exp.waddr);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
    end
  endtask

  //----------------------------------------------------------
  // clock, wb_rdy driver, watchdog
  //----------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    wb_rdy      = 1'b1;
    stall_state = seed;
    forever begin
      @(posedge clk);
      #1;
      stall_state = lcg_next(stall_state);
      wb_rdy = ~stall_en | (stall_state[23:22] != 2'b00); // about 1 in 4 stalls
    end
  end

  initial begin
    repeat (total_ops * 40 + 200) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", total_ops * 40 + 200);
    $display("SIMULATION FAILED");
    $finish;
  end

  //----------------------------------------------------------
  // monitor, sampled at the rising edge
  //----------------------------------------------------------

  always @(posedge clk) begin : monitor
    expect_entry e;
    logic        found;
    if (!rst && wb_val && wb_rdy) begin
      found = 1'b1;
      if (alu_q.size() > 0 && alu_q[0].resp.waddr == wb.waddr) e = alu_q.pop_front();
      else if (mul_q.size() > 0 && mul_q[0].resp.waddr == wb.waddr) e = mul_q.pop_front();
      else found = 1'b0;
      if (!found) begin
        err_cnt++;
        $display("unexpected writeback to x%0d, no pending result for it", wb.waddr);
      end else begin
        check_resp(wb, e.resp);
        if (cycle_cnt - e.accept_cycle < 3) begin
          err_cnt++;
          $display("result for x%0d arrived %0d cycles after acceptance", wb.waddr,
                   cycle_cnt - e.accept_cycle);
        end
        if (wb.waddr == 5'd0 && !wb.wen) zero_seen++;
      end
    end
    if (!rst && req_val && req_rdy) begin
      e.resp         = exec_model(req);
      e.accept_cycle = cycle_cnt;
      if (is_multiply(req.uop)) mul_q.push_back(e);
      else alu_q.push_back(e);
    end
    cycle_cnt++;
  end

  //----------------------------------------------------------
  // sequences
  //----------------------------------------------------------

  // starts and ends 1 ns after an edge
  task automatic send_op(input exec_uop uop, input logic [31:0] a, input logic [31:0] b);
    req.uop   = uop;
    req.op1   = a;
    req.op2   = b;
    req.waddr = next_waddr;
    next_waddr++;
    req_val = 1'b1;
    do begin
      @(posedge clk);
    end while (!req_rdy);
    #1;
    req_val = 1'b0;
    issued++;
  endtask

  task automatic send_random(input int n);
    repeat (n) send_op(uop_at((rand_word() >> 16) % 14), rand_word(), rand_word());
  endtask

  task automatic drain_results();
    int waited = 0;
    while (alu_q.size() + mul_q.size() != 0 && waited < 200) begin
      @(posedge clk);
      #1; // after the monitor ran
      waited++;
    end
    if (alu_q.size() + mul_q.size() != 0) begin
      err_cnt++;
      $display("missing results: %0d expected writebacks never arrived",
               alu_q.size() + mul_q.size());
      alu_q.delete();
      mul_q.delete();
    end
    repeat (4) @(posedge clk); // quiet window, extras show as unexpected
    #1;
  endtask

  task automatic report_test(input string name, input int ops, input int err_before);
    $display("test %s %0d ops %s", name, ops, (err_cnt == err_before) ? "pass" : "fail");
  endtask

  // edge pairs then random pairs for each op in range
  task automatic run_directed(input string name, input int first, input int count);
    int err_before;
    int ops_before;
    err_before = err_cnt;
    ops_before = issued;
    for (int k = first; k < first + count; k++) begin
      for (int i = 0; i < n_edge; i++) begin
        for (int j = 0; j < n_edge; j++) send_op(uop_at(k), edge_val(i), edge_val(j));
      end
      repeat (n_rand) send_op(uop_at(k), rand_word(), rand_word());
    end
    drain_results();
    report_test(name, issued - ops_before, err_before);
  endtask

  initial begin : main
    int err_before;
    int zero_before;
    rst        = 1'b1;
    req_val    = 1'b0;
    req        = '0;
    stall_en   = 1'b0;
    op_state   = seed;
    next_waddr = 5'd0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // idle after reset
    err_before = err_cnt;
    repeat (4) begin
      @(posedge clk);
      check_flag("wb_val", wb_val, 1'b0);
      check_flag("req_rdy", req_rdy, 1'b1);
    end
    #1;
    report_test("reset_idle", 0, err_before);

    run_directed("alu_ops", 0, 10);
    run_directed("mul_ops", 10, 4);

    // x0 writes must come back with wen low
    err_before  = err_cnt;
    zero_before = zero_seen;
    next_waddr  = 5'd1;
    send_random(n_zero);
    drain_results();
    if (zero_seen - zero_before != 2) begin
      err_cnt++;
      $display("expected 2 writes to x0 with wen low, saw %0d", zero_seen - zero_before);
    end
    report_test("reg_zero", n_zero, err_before);

    err_before = err_cnt;
    send_random(n_mixed);
    drain_results();
    report_test("mixed", n_mixed, err_before);

    err_before = err_cnt;
    stall_en   = 1'b1;
    send_random(n_stall);
    drain_results();
    stall_en = 1'b0;
    report_test("wb_stall", n_stall, err_before);

    $display("done: %0d ops issued, %0d checks, %0d errors", issued, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
source/exec_pkg.sv
source/exec_issue.sv
source/exec_alu.sv
source/exec_multiplier.sv
source/exec_wb_arbiter.sv
source/exec_stage.sv
testbench/exec_stage_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - source/exec_pkg.sv
  - source/exec_issue.sv
  - source/exec_alu.sv
  - source/exec_multiplier.sv
  - source/exec_wb_arbiter.sv
  - source/exec_stage.sv
  - target: test
    files:
      - testbench/exec_stage_tb.sv
